//--- Makefile
# Verilator flow for the memory access preparation stage

VERILATOR ?= verilator
TOP       ?= mem_access_prep_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run did not complete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
verilog/excp_pkg.sv
verilog/mem_pkg.sv
verilog/mem_req_stage.sv
verilog/addr_xlate_check.sv
verilog/lane_format.sv
verilog/mem_access_prep.sv
verif/mem_access_prep_assertions.sv
verif/mem_access_prep_tb.sv

//--- verif/mem_access_prep_assertions.sv
module mem_access_prep_assertions
    import mem_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input mem_req_t  req,
    input mem_resp_t resp
);

    // A trapping access never writes
    we_without_exc: assert property (@(posedge clk) disable iff (!arst_n)
        resp.we |-> !resp.exc)
        else $error("Write enable high together with an exception");

    we_re_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(resp.we && resp.re))
        else $error("Read enable and write enable both high");

    // Two register stages from request to response
    resp_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        req.valid |-> ##2 resp.valid)
        else $error("Valid request gave no valid response two cycles later");

endmodule

bind mem_access_prep mem_access_prep_assertions u_assertions (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .resp   (resp)
);

//--- verif/mem_access_prep_tb.sv
module mem_access_prep_tb
    import mem_pkg::*;
    import excp_pkg::*;
();

    logic       clk;
    logic       arst_n;
    mem_req_t   req;
    logic [2:0] k0_attr;
    mem_resp_t  resp;

    string      name_q[$];
    mem_req_t   stim_q[$];
    logic [2:0] k0_q[$];
    mem_resp_t  exp_q[$];
    int         pend_idx[$];   // Requests in flight
    int         pend_due[$];
    int         cyc = 0;
    bit         loaded = 1'b0;

    mem_access_prep DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .k0_attr (k0_attr),
        .resp    (resp)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Test stopped");
    endtask

    task automatic compare_field(input string tname, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            report_failure($sformatf("Fail %s %s expected %h actual %h", tname, field, exp, act));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        string       tname;
        logic        v_v, f_v, tv_v, d_v, unc_v, we_v, re_v, sc_v;
        logic [3:0]  op_v;
        logic [3:0]  ws_v;
        logic [4:0]  rs_v;
        logic [2:0]  ta_v, k0_v;
        logic [19:0] pfn_v;
        logic [31:0] va_v, wd_v, pa_v, ewd_v;
        int          code_v, size_v;
        mem_req_t    r;
        mem_resp_t   e;
        fd = $fopen("verif/mem_access_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("Cannot open verif/mem_access_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.substr(0, 0) != "#") begin
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %b %h %b %d",
                              tname, v_v, op_v, va_v, wd_v, f_v, tv_v, d_v, pfn_v, ta_v, k0_v,
                              pa_v, unc_v, code_v, we_v, re_v, sc_v, ws_v, ewd_v, rs_v, size_v);
                if (cnt > 0 && cnt != 21) begin
                    report_failure($sformatf("Malformed test data line: %s", line));
                end else if (cnt == 21) begin
                    r           = '0;
                    r.valid     = v_v;
                    r.op        = mem_op_e'(op_v);
                    r.vaddr     = va_v;
                    r.wdata     = wd_v;
                    r.tlb.found = f_v;
                    r.tlb.valid = tv_v;
                    r.tlb.dirty = d_v;
                    r.tlb.pfn   = pfn_v;
                    r.tlb.attr  = ta_v;
                    e           = '0;
                    e.valid     = v_v;
                    e.paddr     = pa_v;
                    e.uncached  = unc_v;
                    e.exc_code  = exc_code_e'(code_v[4:0]);
                    e.exc       = (code_v != 0);
                    e.badvaddr  = e.exc ? va_v : '0; // Bad address only on a trap
                    e.we        = we_v;
                    e.re        = re_v;
                    e.sc_ok     = sc_v;
                    e.wstrb     = ws_v;
                    e.wdata     = ewd_v;
                    e.rstrb     = rs_v;
                    e.size      = size_e'(size_v[2:0]);
                    name_q.push_back(tname);
                    stim_q.push_back(r);
                    k0_q.push_back(k0_v);
                    exp_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_response(input int idx);
        mem_resp_t e;
        string     n;
        e = exp_q[idx];
        n = name_q[idx];
        compare_field(n, "valid", 32'(e.valid), 32'(resp.valid));
        compare_field(n, "we", 32'(e.we), 32'(resp.we));
        compare_field(n, "re", 32'(e.re), 32'(resp.re));
        compare_field(n, "exc", 32'(e.exc), 32'(resp.exc));
        if (e.valid) begin
            compare_field(n, "paddr", e.paddr, resp.paddr);
            compare_field(n, "uncached", 32'(e.uncached), 32'(resp.uncached));
            compare_field(n, "exc_code", 32'(e.exc_code), 32'(resp.exc_code));
            compare_field(n, "badvaddr", e.badvaddr, resp.badvaddr);
            compare_field(n, "sc_ok", 32'(e.sc_ok), 32'(resp.sc_ok));
            compare_field(n, "size", 32'(e.size), 32'(resp.size));
            if (stim_q[idx].op >= op_sb) begin // Store group
                compare_field(n, "wstrb", 32'(e.wstrb), 32'(resp.wstrb));
                compare_field(n, "wdata", e.wdata, resp.wdata);
            end else begin
                compare_field(n, "rstrb", 32'(e.rstrb), 32'(resp.rstrb));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Outputs are stable mid cycle
    always @(negedge clk) begin
        if (pend_due.size() != 0 && pend_due[0] == cyc) begin
            check_response(pend_idx[0]);
            void'(pend_idx.pop_front());
            void'(pend_due.pop_front());
        end
    end

    initial begin
        wait (loaded);
        #((name_q.size() + 10) * 4);
        report_failure("Timeout: the expected responses did not all arrive in time");
    end

    initial begin
        int k;
        req     = '0;
        k0_attr = 3'd0;
        arst_n  = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (k = 0; k < stim_q.size(); k++) begin
            @(posedge clk);
            req <= stim_q[k];
            if (k > 0) begin
                k0_attr <= k0_q[k - 1]; // Translation sees k0_attr a cycle after its request
            end
            pend_idx.push_back(k);
            pend_due.push_back(cyc + 3); // Seen at next edge, two stages after
        end
        @(posedge clk);
        req <= '0;
        if (k0_q.size() != 0) begin
            k0_attr <= k0_q[k0_q.size() - 1];
        end
        while (pend_idx.size() != 0) begin
            @(negedge clk);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- verif/mem_access_testdata.txt
# name valid op vaddr wdata tlb_found tlb_valid tlb_dirty pfn tlb_attr k0_attr, then expected:
# paddr uncached exc_code we re sc_ok wstrb wdata rstrb size (lane fields unused by the op are 0)
map_k0_cached      1 4 80001230 00000000 0 0 0 00000 0 3 00001230 0 0 0 1 0 0000 00000000 11111 2
map_k0_uncached    1 4 80001234 00000000 0 0 0 00000 0 2 00001234 1 0 0 1 0 0000 00000000 11111 2
map_kseg1          1 4 a0004568 00000000 0 0 0 00000 0 3 00004568 1 0 0 1 0 0000 00000000 11111 2
map_kuseg          1 4 00403abc 00000000 1 1 0 0abcd 3 2 0abcdabc 0 0 0 1 0 0000 00000000 11111 2
map_kseg2          1 4 c0010ff0 00000000 1 1 0 fedcb 2 3 fedcbff0 1 0 0 1 0 0000 00000000 11111 2
sb_0               1 8 00010000 a1b2c3d4 1 1 1 12345 3 3 12345000 0 0 1 0 0 0001 d4d4d4d4 00000 0
sb_1               1 8 00010001 a1b2c3d4 1 1 1 12345 3 3 12345001 0 0 1 0 0 0010 d4d4d4d4 00000 0
sb_2               1 8 00010002 a1b2c3d4 1 1 1 12345 3 3 12345002 0 0 1 0 0 0100 d4d4d4d4 00000 0
sb_3               1 8 00010003 a1b2c3d4 1 1 1 12345 3 3 12345003 0 0 1 0 0 1000 d4d4d4d4 00000 0
sh_0               1 9 00010000 a1b2c3d4 1 1 1 12345 3 3 12345000 0 0 1 0 0 0011 c3d4c3d4 00000 1
sh_2               1 9 00010002 a1b2c3d4 1 1 1 12345 3 3 12345002 0 0 1 0 0 1100 c3d4c3d4 00000 1
sw_0               1 a 00010000 a1b2c3d4 1 1 1 12345 3 3 12345000 0 0 1 0 0 1111 a1b2c3d4 00000 2
swl_0              1 b 00010000 a1b2c3d4 1 1 1 12345 3 3 12345000 0 0 1 0 0 0001 a1a1a1a1 00000 2
swl_1              1 b 00010001 a1b2c3d4 1 1 1 12345 3 3 12345001 0 0 1 0 0 0011 a1b2a1b2 00000 2
swl_2              1 b 00010002 a1b2c3d4 1 1 1 12345 3 3 12345002 0 0 1 0 0 0111 00a1b2c3 00000 2
swl_3              1 b 00010003 a1b2c3d4 1 1 1 12345 3 3 12345003 0 0 1 0 0 1111 a1b2c3d4 00000 2
swr_0              1 c 00010000 a1b2c3d4 1 1 1 12345 3 3 12345000 0 0 1 0 0 1111 a1b2c3d4 00000 2
swr_1              1 c 00010001 a1b2c3d4 1 1 1 12345 3 3 12345001 0 0 1 0 0 1110 b2c3d400 00000 2
swr_2              1 c 00010002 a1b2c3d4 1 1 1 12345 3 3 12345002 0 0 1 0 0 1100 c3d4c3d4 00000 2
swr_3              1 c 00010003 a1b2c3d4 1 1 1 12345 3 3 12345003 0 0 1 0 0 1000 d4d4d4d4 00000 2
lb_0               1 0 a0000040 00000000 0 0 0 00000 0 3 00000040 1 0 0 1 0 0000 00000000 01000 0
lb_1               1 0 a0000041 00000000 0 0 0 00000 0 3 00000041 1 0 0 1 0 0000 00000000 01001 0
lb_2               1 0 a0000042 00000000 0 0 0 00000 0 3 00000042 1 0 0 1 0 0000 00000000 01010 0
lb_3               1 0 a0000043 00000000 0 0 0 00000 0 3 00000043 1 0 0 1 0 0000 00000000 01011 0
lbu_1              1 1 a0000041 00000000 0 0 0 00000 0 3 00000041 1 0 0 1 0 0000 00000000 00001 0
lbu_3              1 1 a0000043 00000000 0 0 0 00000 0 3 00000043 1 0 0 1 0 0000 00000000 00011 0
lh_2               1 2 a0000042 00000000 0 0 0 00000 0 3 00000042 1 0 0 1 0 0000 00000000 01110 1
lhu_0              1 3 a0000040 00000000 0 0 0 00000 0 3 00000040 1 0 0 1 0 0000 00000000 00100 1
lwl_0              1 5 a0000040 00000000 0 0 0 00000 0 3 00000040 1 0 0 1 0 0000 00000000 11000 2
lwl_1              1 5 a0000041 00000000 0 0 0 00000 0 3 00000041 1 0 0 1 0 0000 00000000 11100 2
lwl_2              1 5 a0000042 00000000 0 0 0 00000 0 3 00000042 1 0 0 1 0 0000 00000000 11110 2
lwl_3              1 5 a0000043 00000000 0 0 0 00000 0 3 00000043 1 0 0 1 0 0000 00000000 11111 2
lwr_0              1 6 a0000040 00000000 0 0 0 00000 0 3 00000040 1 0 0 1 0 0000 00000000 11111 2
lwr_1              1 6 a0000041 00000000 0 0 0 00000 0 3 00000041 1 0 0 1 0 0000 00000000 10111 2
lwr_2              1 6 a0000042 00000000 0 0 0 00000 0 3 00000042 1 0 0 1 0 0000 00000000 10011 2
lwr_3              1 6 a0000043 00000000 0 0 0 00000 0 3 00000043 1 0 0 1 0 0000 00000000 10001 2
ades_sh_tlb_miss   1 9 00010001 a1b2c3d4 0 0 0 00000 0 3 00000001 1 5 0 0 0 0011 c3d4c3d4 00000 1
ades_sw            1 a 80000006 a1b2c3d4 0 0 0 00000 0 3 00000006 0 5 0 0 0 1111 a1b2c3d4 00000 2
adel_lh            1 2 a0000043 00000000 0 0 0 00000 0 3 00000043 1 4 0 0 0 0000 00000000 01110 1
adel_lw_tlb_miss   1 4 00020001 00000000 0 0 0 00000 0 3 00000001 1 4 0 0 0 0000 00000000 11111 2
tlbl_miss          1 0 00030000 00000000 0 0 0 00000 0 3 00000000 1 2 0 0 0 0000 00000000 01000 0
tlbl_invalid       1 4 00030004 00000000 1 0 1 54321 3 3 54321004 0 2 0 0 0 0000 00000000 11111 2
tlbs_miss          1 a 00030008 a1b2c3d4 0 0 0 00000 0 3 00000008 1 3 0 0 0 1111 a1b2c3d4 00000 2
tlbs_invalid       1 8 0003000c a1b2c3d4 1 0 1 54321 3 3 5432100c 0 3 0 0 0 0001 d4d4d4d4 00000 0
tlbmod_clean       1 a 00030010 a1b2c3d4 1 1 0 54321 3 3 54321010 0 1 0 0 0 1111 a1b2c3d4 00000 2
kseg1_store_miss   1 a a0000050 a1b2c3d4 0 0 0 00000 0 3 00000050 1 0 1 0 0 1111 a1b2c3d4 00000 2
ll_link            1 7 80001000 00000000 0 0 0 00000 0 3 00001000 0 0 0 1 0 0000 00000000 11111 2
sc_linked          1 d 80001000 11223344 0 0 0 00000 0 3 00001000 0 0 1 0 1 1111 11223344 00000 2
sc_other_addr      1 d 80001004 11223344 0 0 0 00000 0 3 00001004 0 0 0 0 0 1111 11223344 00000 2
ll_relink          1 7 80002000 00000000 0 0 0 00000 0 3 00002000 0 0 0 1 0 0000 00000000 11111 2
lw_trap            1 4 80000002 00000000 0 0 0 00000 0 3 00000002 0 4 0 0 0 0000 00000000 11111 2
sc_after_trap      1 d 80002000 11223344 0 0 0 00000 0 3 00002000 0 0 0 0 0 1111 11223344 00000 2
bubble             0 0 00000000 00000000 0 0 0 00000 0 3 00000000 0 0 0 0 0 0000 00000000 00000 0

//--- verilog/addr_xlate_check.sv
module addr_xlate_check
    import mem_pkg::*;
    import excp_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_req_t   stage_req,
    input  logic       is_store,
    input  logic       is_load,
    input  logic [2:0] k0_attr,
    output mem_ctl_t   ctl
);

    vaddr_t    va;
    tlb_res_t  tlb;
    logic      valid;
    logic      mapped;
    logic      kseg0;
    logic      tlb_hit;
    logic      ades;
    logic      adel;
    logic      tlbl;
    logic      tlbs;
    logic      tlbmod;
    logic      exc;
    logic      sc_ok;
    logic      store_eff;
    exc_code_e exc_code;
    logic      link_bit;
    vaddr_t    link_addr;

    assign va    = stage_req.vaddr;
    assign tlb   = stage_req.tlb;
    assign valid = stage_req.valid;

    // kuseg and kseg2/3 go through the TLB
    assign mapped = !va[31] || (va[31:30] == 2'b11);
    assign kseg0  = (va[31:29] == seg_kseg0);

    assign tlb_hit = tlb.found && tlb.valid;

    // SC only counts as a store when the link still holds
    assign sc_ok     = valid && (stage_req.op == op_sc) && link_bit && (link_addr == va);
    assign store_eff = is_store && ((stage_req.op != op_sc) || sc_ok);

    assign ades = valid && (((stage_req.op == op_sh) && va[0])
                  || ((stage_req.op inside {op_sw, op_sc}) && (va[1:0] != 2'b00)));
    assign adel = valid && (((stage_req.op inside {op_lh, op_lhu}) && va[0])
                  || ((stage_req.op inside {op_lw, op_ll}) && (va[1:0] != 2'b00)));

    assign tlbl   = valid && mapped && is_load && !tlb_hit;
    assign tlbs   = valid && mapped && store_eff && !tlb_hit;
    assign tlbmod = valid && mapped && store_eff && tlb_hit && !tlb.dirty;

    assign exc = ades || adel || tlbl || tlbs || tlbmod;

    always_comb begin
        if (ades) begin
            exc_code = exc_ades;
        end else if (adel) begin
            exc_code = exc_adel;
        end else if (tlbl) begin
            exc_code = exc_tlbl;
        end else if (tlbs) begin
            exc_code = exc_tlbs;
        end else if (tlbmod) begin
            exc_code = exc_mod;
        end else begin
            exc_code = exc_none;
        end
    end

    // Link survives until an LL replaces it or anything traps
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            link_bit  <= 1'b0;
            link_addr <= '0;
        end else if (exc) begin
            link_bit  <= 1'b0;
            link_addr <= '0;
        end else if (valid && (stage_req.op == op_ll)) begin
            link_bit  <= 1'b1;
            link_addr <= va;
        end
    end

    always_comb begin
        ctl.valid    = valid;
        ctl.op       = stage_req.op;
        ctl.paddr    = mapped ? {tlb.pfn, va[page_off_w-1:0]} : {3'b000, va[28:0]};
        ctl.uncached = !((kseg0 && (k0_attr == attr_cached))
                         || (mapped && (tlb.attr == attr_cached)));
        ctl.wdata    = stage_req.wdata;
        ctl.exc      = exc;
        ctl.exc_code = exc_code;
        ctl.badvaddr = exc ? va : '0;
        ctl.we       = valid && store_eff && !exc;
        ctl.re       = valid && is_load && !exc;
        ctl.sc_ok    = sc_ok && !exc; // A trapping SC never completes
    end

endmodule

//--- verilog/excp_pkg.sv
package excp_pkg;

    localparam int pfn_w = 20;

    // Cache attribute encoding, 3 is cacheable noncoherent
    localparam logic [2:0] attr_cached = 3'd3;

    // Cause register codes
    typedef enum logic [4:0] {
        exc_none  = 5'd0,
        exc_mod   = 5'd1,
        exc_tlbl  = 5'd2,
        exc_tlbs  = 5'd3,
        exc_adel  = 5'd4,
        exc_ades  = 5'd5
    } exc_code_e;

    // Result of the data side TLB lookup
    typedef struct packed {
        logic             found;
        logic             valid;
        logic             dirty;
        logic [pfn_w-1:0] pfn;
        logic [2:0]       attr;
    } tlb_res_t;

endpackage

//--- verilog/lane_format.sv
module lane_format
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mem_ctl_t  ctl,
    output mem_resp_t resp
);

    logic [1:0] off;
    word_t      rt;
    mem_resp_t  nxt;
    mem_resp_t  resp_q;
    logic       valid_q;
    logic       we_q;
    logic       re_q;
    logic       exc_q;

    assign off = ctl.paddr[1:0];
    assign rt  = ctl.wdata;

    always_comb begin
        nxt.valid    = ctl.valid;
        nxt.paddr    = ctl.paddr;
        nxt.uncached = ctl.uncached;
        nxt.exc      = ctl.exc;
        nxt.exc_code = ctl.exc_code;
        nxt.badvaddr = ctl.badvaddr;
        nxt.we       = ctl.we;
        nxt.re       = ctl.re;
        nxt.sc_ok    = ctl.sc_ok;
        nxt.wstrb    = wstrb_all;     // SW, SC
        nxt.wdata    = rt;
        nxt.rstrb    = rstrb_all;     // LW, LL
        nxt.size     = size_word;
        case (ctl.op)
            op_sb: begin
                nxt.wstrb = 4'b0001 << off;
                nxt.wdata = {4{rt[7:0]}};
                nxt.size  = size_byte;
            end
            op_sh: begin
                nxt.wstrb = off[1] ? 4'b1100 : 4'b0011;
                nxt.wdata = {2{rt[15:0]}};
                nxt.size  = size_half;
            end
            op_swl: begin
                nxt.wstrb = wstrb_all >> (2'd3 - off); // Upper bytes into low lanes
                case (off)
                    2'b00:   nxt.wdata = {4{rt[31:24]}};
                    2'b01:   nxt.wdata = {2{rt[31:16]}};
                    2'b10:   nxt.wdata = {8'b0, rt[31:8]};
                    default: nxt.wdata = rt;
                endcase
            end
            op_swr: begin
                nxt.wstrb = wstrb_all << off;
                case (off)
                    2'b00:   nxt.wdata = rt;
                    2'b01:   nxt.wdata = {rt[23:0], 8'b0};
                    2'b10:   nxt.wdata = {2{rt[15:0]}};
                    default: nxt.wdata = {4{rt[7:0]}};
                endcase
            end
            op_lbu: begin
                nxt.rstrb = {3'b000, off};
                nxt.size  = size_byte;
            end
            op_lb: begin
                nxt.rstrb = {3'b010, off};
                nxt.size  = size_byte;
            end
            op_lhu: begin
                nxt.rstrb = {3'b001, off[1], 1'b0};
                nxt.size  = size_half;
            end
            op_lh: begin
                nxt.rstrb = {3'b011, off[1], 1'b0};
                nxt.size  = size_half;
            end
            op_lwl: begin
                case (off)
                    2'b00:   nxt.rstrb = 5'b11000;
                    2'b01:   nxt.rstrb = 5'b11100;
                    2'b10:   nxt.rstrb = 5'b11110;
                    default: nxt.rstrb = 5'b11111;
                endcase
            end
            op_lwr: begin
                case (off)
                    2'b00:   nxt.rstrb = 5'b11111;
                    2'b01:   nxt.rstrb = 5'b10111;
                    2'b10:   nxt.rstrb = 5'b10011;
                    default: nxt.rstrb = 5'b10001;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
            re_q    <= 1'b0;
            exc_q   <= 1'b0;
        end else begin
            valid_q <= nxt.valid;
            we_q    <= nxt.we;
            re_q    <= nxt.re;
            exc_q   <= nxt.exc;
        end
    end

    always_ff @(posedge clk) begin
        resp_q <= nxt;
    end

    // Control bits come from the reset flops
    always_comb begin
        resp       = resp_q;
        resp.valid = valid_q;
        resp.we    = we_q;
        resp.re    = re_q;
        resp.exc   = exc_q;
    end

endmodule

//--- verilog/mem_access_prep.sv
module mem_access_prep
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mem_req_t   req,
    input  logic [2:0] k0_attr,
    output mem_resp_t  resp
);

    mem_req_t stage_req;
    mem_ctl_t ctl;
    logic     is_store;
    logic     is_load;

    mem_req_stage u_req_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .stage_req (stage_req),
        .is_store  (is_store),
        .is_load   (is_load)
    );

    addr_xlate_check u_xlate (
        .clk       (clk),
        .arst_n    (arst_n),
        .stage_req (stage_req),
        .is_store  (is_store),
        .is_load   (is_load),
        .k0_attr   (k0_attr),
        .ctl       (ctl)
    );

    lane_format u_lanes (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl),
        .resp   (resp)
    );

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;
    import excp_pkg::*;

    localparam int addr_w = 32;
    localparam int page_off_w = 12;

    localparam logic [2:0] seg_kseg0 = 3'b100; // Unmapped, cache from k0
    localparam logic [3:0] wstrb_all = 4'b1111;
    localparam logic [4:0] rstrb_all = 5'b11111;

    typedef logic [addr_w-1:0] vaddr_t;
    typedef logic [addr_w-1:0] word_t;
    typedef logic [3:0] wstrb_t;
    typedef logic [4:0] rstrb_t;   // {full, signed, half, byte offset}

    // Loads in the lower half, stores in the upper half
    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lbu = 4'd1,
        op_lh  = 4'd2,
        op_lhu = 4'd3,
        op_lw  = 4'd4,
        op_lwl = 4'd5,
        op_lwr = 4'd6,
        op_ll  = 4'd7,
        op_sb  = 4'd8,
        op_sh  = 4'd9,
        op_sw  = 4'd10,
        op_swl = 4'd11,
        op_swr = 4'd12,
        op_sc  = 4'd13
    } mem_op_e;

    typedef enum logic [2:0] {
        size_byte = 3'd0,
        size_half = 3'd1,
        size_word = 3'd2
    } size_e;

    typedef struct packed {
        logic     valid;
        mem_op_e  op;
        vaddr_t   vaddr;
        word_t    wdata;
        tlb_res_t tlb;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        vaddr_t    paddr;
        logic      uncached;
        word_t     wdata;     // Raw store data, not yet lane aligned
        logic      exc;
        exc_code_e exc_code;
        vaddr_t    badvaddr;
        logic      we;
        logic      re;
        logic      sc_ok;
    } mem_ctl_t;

    typedef struct packed {
        logic      valid;
        vaddr_t    paddr;
        logic      uncached;
        logic      exc;
        exc_code_e exc_code;
        vaddr_t    badvaddr;
        logic      we;
        logic      re;
        logic      sc_ok;
        wstrb_t    wstrb;
        word_t     wdata;
        rstrb_t    rstrb;
        size_e     size;
    } mem_resp_t;

endpackage

//--- verilog/mem_req_stage.sv
module mem_req_stage
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t req,
    output mem_req_t stage_req,
    output logic     is_store,
    output logic     is_load
);

    logic     valid_q;
    mem_req_t req_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // Payload only, valid travels in valid_q
    always_ff @(posedge clk) begin
        req_q <= req;
    end

    always_comb begin
        stage_req       = req_q;
        stage_req.valid = valid_q;
    end

    assign is_store = stage_req.op inside {op_sb, op_sh, op_sw, op_swl, op_swr, op_sc};

    assign is_load = stage_req.op inside {
        op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr, op_ll
    };

endmodule
